// File: lsu.f
lsu_pkg.sv
lsu_decode.sv
lsu_store_seq.sv
lsu_row_pack.sv
lsu_top.sv
tb_lsu.sv

// File: lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode import lsu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,

    // from idu
    input  logic          idu_lsu_vld,
    input  logic          idu_lsu_st_iram,
    input  logic          idu_lsu_st_wram,
    input  count_t        idu_lsu_num,
    input  len_code_t     idu_lsu_len,
    input  byte_pos_t     idu_lsu_start_x,
    input  row_idx_t      idu_lsu_start_y,
    input  ld_st_addr_t   idu_lsu_ld_st_addr,

    // from store sequencer
    input  logic          seq_done,

    // to idu
    output logic          lsu_idu_rdy,

    // to store sequencer
    output logic          seq_start,
    output count_t        st_num,
    output row_idx_t      st_start_y,
    output sram_addr_t    st_base_addr,

    // to row pack
    output byte_pos_t     st_start_x,
    output len_code_t     st_len,
    output store_target_e st_target
);

    logic          busy;
    logic          accept;
    store_target_e target_nxt;

    assign lsu_idu_rdy = ~busy;
    assign accept      = idu_lsu_vld & lsu_idu_rdy;

    // iram wins when both flags are set
    always_comb begin
        if (idu_lsu_st_iram) begin
            target_nxt = target_iram;
        end else if (idu_lsu_st_wram) begin
            target_nxt = target_wram;
        end else begin
            target_nxt = target_none;
        end
    end

    // busy from accept until the sequencer reports the last row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            seq_start <= 1'b0;
            st_target <= target_none;
        end else begin
            seq_start <= accept;
            if (accept) begin
                busy      <= 1'b1;
                st_target <= target_nxt;
            end else if (seq_done) begin
                busy <= 1'b0;
            end
        end
    end

    // instruction fields, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            st_num       <= idu_lsu_num;
            st_start_y   <= idu_lsu_start_y;
            st_base_addr <= idu_lsu_ld_st_addr[11:4];
            st_start_x   <= idu_lsu_start_x;
            st_len       <= idu_lsu_len;
        end
    end

    // done only ever closes an instruction that is in flight
    a_done_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        seq_done |-> busy
    );

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

    // bytes per int8 result row
    localparam int ROW_BYTES = 16;

    // one int8 row from the matrix unit
    typedef logic [ROW_BYTES*8-1:0] row_t;

    // all sixteen rows side by side, row 0 in the low bits
    typedef row_t [ROW_BYTES-1:0] mxu_rows_t;

    // row index into the MXU result block
    typedef logic [3:0] row_idx_t;

    // byte position inside a row
    typedef logic [3:0] byte_pos_t;

    // window length code, 2^L bytes
    typedef logic [2:0] len_code_t;

    // rows per store instruction
    typedef logic [7:0] count_t;

    // byte address as carried in the instruction
    typedef logic [11:0] ld_st_addr_t;

    // SRAM word address, ld_st_addr[11:4]
    typedef logic [7:0] sram_addr_t;

    // store destination after flag priority
    typedef enum logic [1:0] {
        target_none = 2'd0,
        target_iram = 2'd1,
        target_wram = 2'd2
    } store_target_e;

    // store sequencer states
    typedef enum logic {
        seq_idle = 1'b0,
        seq_run  = 1'b1
    } seq_state_e;

endpackage

// File: lsu_row_pack.sv
`timescale 1ns/1ps

module lsu_row_pack import lsu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,

    // from store sequencer
    input  logic          row_issue,
    input  row_idx_t      issue_row,
    input  sram_addr_t    issue_addr,

    // latched instruction fields
    input  byte_pos_t     st_start_x,
    input  len_code_t     st_len,
    input  store_target_e st_target,

    // from mxu
    input  mxu_rows_t     mxu_lsu_int8_rows,

    // iram write port
    output logic          lsu_iram_we,
    output sram_addr_t    lsu_iram_addr,
    output row_t          lsu_iram_din,

    // wram write port
    output logic          lsu_wram_we,
    output sram_addr_t    lsu_wram_addr,
    output row_t          lsu_wram_din
);

    row_t                 sel_row;
    row_t                 masked_row;
    logic [4:0]           win_len;
    logic [5:0]           win_end;
    logic [ROW_BYTES-1:0] byte_keep;
    logic                 iram_hit;
    logic                 wram_hit;

    assign sel_row = mxu_lsu_int8_rows[issue_row];

    // codes 4 and up cover the whole row
    always_comb begin
        case (st_len)
            3'd0:    win_len = 5'd1;
            3'd1:    win_len = 5'd2;
            3'd2:    win_len = 5'd4;
            3'd3:    win_len = 5'd8;
            default: win_len = 5'd16;
        endcase
    end

    // window end may run past byte 15, the loop bound clips it
    assign win_end = {2'b00, st_start_x} + {1'b0, win_len};

    always_comb begin
        for (int i = 0; i < ROW_BYTES; i++) begin
            byte_keep[i] = (6'(i) >= {2'b00, st_start_x}) && (6'(i) < win_end);
            masked_row[i*8 +: 8] = byte_keep[i] ? sel_row[i*8 +: 8] : 8'h00;
        end
    end

    assign iram_hit = row_issue && (st_target == target_iram);
    assign wram_hit = row_issue && (st_target == target_wram);

    // strobes are a single cycle after the issue edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_iram_we <= 1'b0;
            lsu_wram_we <= 1'b0;
        end else begin
            lsu_iram_we <= iram_hit;
            lsu_wram_we <= wram_hit;
        end
    end

    // idle port carries zeros
    always_ff @(posedge clk) begin
        lsu_iram_addr <= iram_hit ? issue_addr : '0;
        lsu_iram_din  <= iram_hit ? masked_row : '0;
        lsu_wram_addr <= wram_hit ? issue_addr : '0;
        lsu_wram_din  <= wram_hit ? masked_row : '0;
    end

    // one store targets one SRAM
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(lsu_iram_we && lsu_wram_we)
    );

endmodule

// File: lsu_store_seq.sv
`timescale 1ns/1ps

module lsu_store_seq import lsu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,

    // from decode
    input  logic          seq_start,
    input  count_t        st_num,
    input  row_idx_t      st_start_y,
    input  sram_addr_t    st_base_addr,
    input  store_target_e st_target,

    // from mxu
    input  logic          mxu_lsu_data_rdy,

    // to row pack
    output logic          row_issue,
    output row_idx_t      issue_row,
    output sram_addr_t    issue_addr,

    // to decode
    output logic          seq_done
);

    seq_state_e state;
    count_t     remaining;
    row_idx_t   row_q;
    sram_addr_t addr_q;
    logic       skip;
    logic       last_issue;

    // nothing to write: zero rows or no target flag
    assign skip = (st_num == '0) || (st_target == target_none);

    // one row per edge while running and the mxu has data
    assign row_issue  = (state == seq_run) && mxu_lsu_data_rdy;
    assign last_issue = row_issue && (remaining == count_t'(1));

    assign issue_row  = row_q;
    assign issue_addr = addr_q;

    // empty instructions retire straight from the start pulse
    assign seq_done = (seq_start && skip) || last_issue;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= seq_idle;
            remaining <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (seq_start && !skip) begin
                        state     <= seq_run;
                        remaining <= st_num;
                    end
                end
                seq_run: begin
                    if (row_issue) begin
                        remaining <= remaining - count_t'(1);
                        if (last_issue) begin
                            state <= seq_idle;
                        end
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // row index wraps mod 16, address mod 256
    always_ff @(posedge clk) begin
        if (seq_start) begin
            row_q  <= st_start_y;
            addr_q <= st_base_addr;
        end else if (row_issue) begin
            row_q  <= row_q + row_idx_t'(1);
            addr_q <= addr_q + sram_addr_t'(1);
        end
    end

    // a start never lands on a store that is still issuing
    a_no_start_while_issuing: assert property (
        @(posedge clk) disable iff (!rst_n)
        row_issue |-> !seq_start
    );

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // from idu
    input  logic        idu_lsu_vld,
    input  logic        idu_lsu_st_iram,
    input  logic        idu_lsu_st_wram,
    input  count_t      idu_lsu_num,
    input  len_code_t   idu_lsu_len,
    input  byte_pos_t   idu_lsu_start_x,
    input  row_idx_t    idu_lsu_start_y,
    input  ld_st_addr_t idu_lsu_ld_st_addr,

    // from mxu
    input  mxu_rows_t   mxu_lsu_int8_rows,
    input  logic        mxu_lsu_data_rdy,

    // to idu
    output logic        lsu_idu_rdy,

    // sram write ports
    output logic        lsu_iram_we,
    output sram_addr_t  lsu_iram_addr,
    output row_t        lsu_iram_din,
    output logic        lsu_wram_we,
    output sram_addr_t  lsu_wram_addr,
    output row_t        lsu_wram_din
);

    logic          seq_start;
    logic          seq_done;
    count_t        st_num;
    row_idx_t      st_start_y;
    sram_addr_t    st_base_addr;
    byte_pos_t     st_start_x;
    len_code_t     st_len;
    store_target_e st_target;

    logic          row_issue;
    row_idx_t      issue_row;
    sram_addr_t    issue_addr;

    lsu_decode u_decode (
        .clk                (clk),
        .rst_n              (rst_n),
        .idu_lsu_vld        (idu_lsu_vld),
        .idu_lsu_st_iram    (idu_lsu_st_iram),
        .idu_lsu_st_wram    (idu_lsu_st_wram),
        .idu_lsu_num        (idu_lsu_num),
        .idu_lsu_len        (idu_lsu_len),
        .idu_lsu_start_x    (idu_lsu_start_x),
        .idu_lsu_start_y    (idu_lsu_start_y),
        .idu_lsu_ld_st_addr (idu_lsu_ld_st_addr),
        .seq_done           (seq_done),
        .lsu_idu_rdy        (lsu_idu_rdy),
        .seq_start          (seq_start),
        .st_num             (st_num),
        .st_start_y         (st_start_y),
        .st_base_addr       (st_base_addr),
        .st_start_x         (st_start_x),
        .st_len             (st_len),
        .st_target          (st_target)
    );

    lsu_store_seq u_store_seq (
        .clk              (clk),
        .rst_n            (rst_n),
        .seq_start        (seq_start),
        .st_num           (st_num),
        .st_start_y       (st_start_y),
        .st_base_addr     (st_base_addr),
        .st_target        (st_target),
        .mxu_lsu_data_rdy (mxu_lsu_data_rdy),
        .row_issue        (row_issue),
        .issue_row        (issue_row),
        .issue_addr       (issue_addr),
        .seq_done         (seq_done)
    );

    lsu_row_pack u_row_pack (
        .clk               (clk),
        .rst_n             (rst_n),
        .row_issue         (row_issue),
        .issue_row         (issue_row),
        .issue_addr        (issue_addr),
        .st_start_x        (st_start_x),
        .st_len            (st_len),
        .st_target         (st_target),
        .mxu_lsu_int8_rows (mxu_lsu_int8_rows),
        .lsu_iram_we       (lsu_iram_we),
        .lsu_iram_addr     (lsu_iram_addr),
        .lsu_iram_din      (lsu_iram_din),
        .lsu_wram_we       (lsu_wram_we),
        .lsu_wram_addr     (lsu_wram_addr),
        .lsu_wram_din      (lsu_wram_din)
    );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the run by its log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f lsu.f \
    --top-module tb_lsu -o tb_lsu_sim
./obj_dir/tb_lsu_sim | tee sim.log
if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    localparam logic [31:0] SEED           = 32'heb721a15;
    localparam int          TIMEOUT_CYCLES = 200 * 40;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          idu_lsu_vld;
    logic          idu_lsu_st_iram;
    logic          idu_lsu_st_wram;
    count_t        idu_lsu_num;
    len_code_t     idu_lsu_len;
    byte_pos_t     idu_lsu_start_x;
    row_idx_t      idu_lsu_start_y;
    ld_st_addr_t   idu_lsu_ld_st_addr;
    mxu_rows_t     mxu_rows;
    logic          mxu_lsu_data_rdy;
    logic          lsu_idu_rdy;
    logic          lsu_iram_we;
    sram_addr_t    lsu_iram_addr;
    row_t          lsu_iram_din;
    logic          lsu_wram_we;
    sram_addr_t    lsu_wram_addr;
    row_t          lsu_wram_din;

    logic [31:0]   seed_q;
    logic [31:0]   rdy_state;
    logic          toggle_rdy;
    logic          data_rdy_at_edge;
    int            cycle_count;
    int            errors;
    int            errors_at_start;
    int            tests_run;
    int            tests_failed;
    int            writes_seen;

    // expected writes in issue order, plus sram images
    store_target_e exp_tgt [$];
    sram_addr_t    exp_addr [$];
    row_t          exp_data [$];
    logic          exp_last [$];
    row_t          iram_mem [256];
    row_t          wram_mem [256];
    row_t          exp_iram [256];
    row_t          exp_wram [256];

    lsu_top dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .idu_lsu_vld        (idu_lsu_vld),
        .idu_lsu_st_iram    (idu_lsu_st_iram),
        .idu_lsu_st_wram    (idu_lsu_st_wram),
        .idu_lsu_num        (idu_lsu_num),
        .idu_lsu_len        (idu_lsu_len),
        .idu_lsu_start_x    (idu_lsu_start_x),
        .idu_lsu_start_y    (idu_lsu_start_y),
        .idu_lsu_ld_st_addr (idu_lsu_ld_st_addr),
        .mxu_lsu_int8_rows  (mxu_rows),
        .mxu_lsu_data_rdy   (mxu_lsu_data_rdy),
        .lsu_idu_rdy        (lsu_idu_rdy),
        .lsu_iram_we        (lsu_iram_we),
        .lsu_iram_addr      (lsu_iram_addr),
        .lsu_iram_din       (lsu_iram_din),
        .lsu_wram_we        (lsu_wram_we),
        .lsu_wram_addr      (lsu_wram_addr),
        .lsu_wram_din       (lsu_wram_din)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        seed_q = xorshift32(seed_q);
        return seed_q;
    endfunction

    // keep bytes sx .. sx+2^len-1, nothing past byte 15
    function automatic row_t apply_window(input row_t row, input byte_pos_t sx,
                                          input len_code_t len);
        int   nbytes;
        int   lo;
        row_t res;
        nbytes = (len > 3'd3) ? 16 : (1 << len);
        lo     = int'(sx);
        res    = '0;
        for (int b = 0; b < ROW_BYTES; b++) begin
            if (b >= lo && b < lo + nbytes) begin
                res[b*8 +: 8] = row[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic randomize_rows();
        for (int r = 0; r < ROW_BYTES; r++) begin
            mxu_rows[r] = {rand32(), rand32(), rand32(), rand32()};
        end
    endtask

    task automatic push_store(input logic iram, input logic wram, input count_t num,
                              input len_code_t len, input byte_pos_t sx, input row_idx_t sy,
                              input ld_st_addr_t addr);
        store_target_e tgt;
        row_idx_t      ridx;
        sram_addr_t    waddr;
        row_t          data;
        tgt   = iram ? target_iram : (wram ? target_wram : target_none);
        ridx  = sy;
        waddr = addr[11:4];
        if (tgt != target_none) begin
            for (int k = 0; k < int'(num); k++) begin
                data = apply_window(mxu_rows[ridx], sx, len);
                exp_tgt.push_back(tgt);
                exp_addr.push_back(waddr);
                exp_data.push_back(data);
                exp_last.push_back(k == int'(num) - 1);
                if (tgt == target_iram) begin
                    exp_iram[waddr] = data;
                end else begin
                    exp_wram[waddr] = data;
                end
                ridx  = ridx + 4'd1;
                waddr = waddr + 8'd1;
            end
        end
    endtask

    // fields held until accept, rows change only once the unit is free
    task automatic send_instr(input logic iram, input logic wram, input count_t num,
                              input len_code_t len, input byte_pos_t sx, input row_idx_t sy,
                              input ld_st_addr_t addr);
        idu_lsu_vld        = 1'b1;
        idu_lsu_st_iram    = iram;
        idu_lsu_st_wram    = wram;
        idu_lsu_num        = num;
        idu_lsu_len        = len;
        idu_lsu_start_x    = sx;
        idu_lsu_start_y    = sy;
        idu_lsu_ld_st_addr = addr;
        while (!lsu_idu_rdy) begin
            @(posedge clk);
            #1;
        end
        randomize_rows();
        push_store(iram, wram, num, len, sx, sy, addr);
        @(posedge clk);
        #1;
        idu_lsu_vld = 1'b0;
    endtask

    task automatic send_random(input logic iram, input logic wram, input int num_max);
        logic [31:0] r;
        r = rand32();
        send_instr(iram, wram, count_t'(1 + int'(r[7:0]) % num_max), r[10:8], r[14:11],
                   r[18:15], r[30:19]);
    endtask

    task automatic wait_idle();
        while (!(lsu_idu_rdy && exp_tgt.size() == 0)) begin
            @(posedge clk);
            #1;
        end
    endtask

    // empty store: rdy back the cycle after the start pulse
    task automatic check_empty_retire(input logic iram, input logic wram, input count_t num);
        send_instr(iram, wram, num, 3'd7, 4'd0, 4'd3, 12'h120);
        @(posedge clk);
        #1;
        assert (lsu_idu_rdy) else begin
            $display("lsu_idu_rdy did not return the cycle after an empty store");
            errors++;
        end
    endtask

    task automatic set_rdy_mode(input logic on);
        @(negedge clk);
        toggle_rdy = on;
        @(posedge clk);
        #1;
    endtask

    task automatic check_write(input store_target_e tgt, input string port,
                               input sram_addr_t addr, input row_t din);
        store_target_e e_tgt;
        sram_addr_t    e_addr;
        row_t          e_data;
        logic          e_last;
        writes_seen++;
        if (tgt == target_iram) begin
            iram_mem[addr] = din;
        end else begin
            wram_mem[addr] = din;
        end
        assert (data_rdy_at_edge) else begin
            $display("%s_we high although mxu_lsu_data_rdy was low at the issue edge", port);
            errors++;
        end
        assert (exp_tgt.size() > 0) else begin
            $display("unexpected write strobe on %s_we at address %h", port, addr);
            errors++;
        end
        if (exp_tgt.size() > 0) begin
            e_tgt  = exp_tgt.pop_front();
            e_addr = exp_addr.pop_front();
            e_data = exp_data.pop_front();
            e_last = exp_last.pop_front();
            assert (tgt == e_tgt) else begin
                $display("Mismatch %s_we target: got %h expected %h", port, tgt, e_tgt);
                errors++;
            end
            assert (addr == e_addr) else begin
                $display("Mismatch %s_addr: got %h expected %h", port, addr, e_addr);
                errors++;
            end
            assert (din == e_data) else begin
                $display("Mismatch %s_din: got %h expected %h", port, din, e_data);
                errors++;
            end
            // rdy comes back together with the last write of a store
            assert (lsu_idu_rdy == e_last) else begin
                $display("Mismatch lsu_idu_rdy: got %h expected %h", lsu_idu_rdy, e_last);
                errors++;
            end
        end
    endtask

    // port not targeted by the current write stays at zero
    task automatic check_idle_port(input string port, input sram_addr_t addr,
                                   input row_t din);
        assert (addr == '0) else begin
            $display("Mismatch %s_addr: got %h expected %h", port, addr, 8'h00);
            errors++;
        end
        assert (din == '0) else begin
            $display("Mismatch %s_din: got %h expected %h", port, din, row_t'(0));
            errors++;
        end
    endtask

    task automatic compare_memories();
        assert (exp_tgt.size() == 0) else begin
            $display("%0d expected writes never reached the SRAM ports", exp_tgt.size());
            errors++;
        end
        for (int a = 0; a < 256; a++) begin
            assert (iram_mem[a] == exp_iram[a]) else begin
                $display("Mismatch iram[%h]: got %h expected %h", 8'(a), iram_mem[a],
                         exp_iram[a]);
                errors++;
            end
            assert (wram_mem[a] == exp_wram[a]) else begin
                $display("Mismatch wram[%h]: got %h expected %h", 8'(a), wram_mem[a],
                         exp_wram[a]);
                errors++;
            end
        end
    endtask

    task automatic end_test(input int id, input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // data_rdy value seen by the DUT at each edge
    always @(posedge clk) begin
        data_rdy_at_edge = mxu_lsu_data_rdy;
    end

    always @(posedge clk) begin
        #1;
        if (toggle_rdy) begin
            rdy_state        = xorshift32(rdy_state);
            mxu_lsu_data_rdy = rdy_state[7];
        end else begin
            mxu_lsu_data_rdy = 1'b1;
        end
    end

    // write ports sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (lsu_iram_we) begin
                check_write(target_iram, "lsu_iram", lsu_iram_addr, lsu_iram_din);
                check_idle_port("lsu_wram", lsu_wram_addr, lsu_wram_din);
            end
            if (lsu_wram_we) begin
                check_write(target_wram, "lsu_wram", lsu_wram_addr, lsu_wram_din);
                check_idle_port("lsu_iram", lsu_iram_addr, lsu_iram_din);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d writes outstanding", cycle_count,
                     exp_tgt.size());
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] pick;
        rst_n              = 1'b0;
        idu_lsu_vld        = 1'b0;
        idu_lsu_st_iram    = 1'b0;
        idu_lsu_st_wram    = 1'b0;
        idu_lsu_num        = '0;
        idu_lsu_len        = '0;
        idu_lsu_start_x    = '0;
        idu_lsu_start_y    = '0;
        idu_lsu_ld_st_addr = '0;
        mxu_rows           = '0;
        mxu_lsu_data_rdy   = 1'b1;
        seed_q             = SEED;
        rdy_state          = xorshift32(SEED);
        toggle_rdy         = 1'b0;
        data_rdy_at_edge   = 1'b1;
        cycle_count        = 0;
        errors             = 0;
        errors_at_start    = 0;
        tests_run          = 0;
        tests_failed       = 0;
        writes_seen        = 0;
        for (int a = 0; a < 256; a++) begin
            iram_mem[a] = {16{8'(a)}};
            wram_mem[a] = {16{8'(a)}};
            exp_iram[a] = {16{8'(a)}};
            exp_wram[a] = {16{8'(a)}};
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        assert (lsu_idu_rdy && !lsu_iram_we && !lsu_wram_we) else begin
            $display("after reset lsu_idu_rdy is low or a write strobe is high");
            errors++;
        end
        end_test(1, "reset state");

        // row index and address both wrap
        send_instr(1'b1, 1'b0, 8'd5, 3'd7, 4'd0, 4'd14, 12'hff0);
        wait_idle();
        repeat (40) begin
            send_random(1'b1, 1'b0, 16);
            wait_idle();
        end
        end_test(2, "iram stores");

        // windows that run past byte 15
        send_instr(1'b0, 1'b1, 8'd3, 3'd3, 4'd12, 4'd0, 12'h400);
        wait_idle();
        send_instr(1'b0, 1'b1, 8'd2, 3'd7, 4'd15, 4'd9, 12'h7a0);
        wait_idle();
        repeat (40) begin
            send_random(1'b0, 1'b1, 16);
            wait_idle();
        end
        end_test(3, "wram windows");

        send_instr(1'b1, 1'b1, 8'd4, 3'd2, 4'd1, 4'd6, 12'h230);
        wait_idle();
        check_empty_retire(1'b0, 1'b0, 8'd6);
        check_empty_retire(1'b1, 1'b0, 8'd0);
        check_empty_retire(1'b0, 1'b1, 8'd0);
        wait_idle();
        end_test(4, "flag priority and empty stores");

        set_rdy_mode(1'b1);
        repeat (40) begin
            pick = rand32();
            send_random(pick[0], pick[1], 12);
            wait_idle();
        end
        set_rdy_mode(1'b0);
        wait_idle();
        compare_memories();
        end_test(5, "data_rdy stalls");

        // next instruction waits on vld, taken as soon as rdy rises
        repeat (20) begin
            pick = rand32();
            send_random(pick[0], pick[1], 8);
        end
        wait_idle();
        compare_memories();
        end_test(6, "back-to-back");

        $display("%0d tests run, %0d failed, %0d writes checked, %0d errors", tests_run,
                 tests_failed, writes_seen, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
